// File: sources.f
+incdir+hdl
hdl/sbit_pkg.sv
hdl/sbit_sequencer.sv
hdl/sbit_decode.sv
hdl/sbit_alu.sv
hdl/sbit_rf.sv
hdl/sbit_store_buf.sv
hdl/sbit_core.sv
verif/sbit_assertions.sv
verif/sbit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the sbit_core testbench with Verilator.
# The exit status is nonzero when the simulation ends in $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module sbit_tb \
   -f sources.f \
   -o sbit_sim

./obj_dir/sbit_sim

// File: verif/sbit_tb.sv
`timescale 1ns/1ps
`include "sbit_settings.svh"

module sbit_tb;

   localparam int PROG_LEN = 60;
   localparam int TIMEOUT  = 60 * PROG_LEN;
   // funct3 of ADDI, XORI, ORI, ANDI packed three bits each
   localparam logic [11:0] IMM_F3 = 12'b111_110_100_000;

   typedef struct packed {
      sbit_pkg::word_t adr;
      sbit_pkg::word_t dat;
   } store_t;

   logic            clk        = 1'b0;
   logic            i_rst_n;
   sbit_pkg::word_t o_ibus_adr;
   logic            o_ibus_cyc;
   sbit_pkg::word_t i_ibus_rdt = '0;
   logic            i_ibus_ack = 1'b0;
   sbit_pkg::word_t o_dbus_adr;
   sbit_pkg::word_t o_dbus_dat;
   logic            o_dbus_cyc;
   logic            i_dbus_ack = 1'b0;

   logic [15:0]     lfsr_q;
   sbit_pkg::word_t imem [0:PROG_LEN-1];
   sbit_pkg::word_t xreg [0:31] = '{default: '0};
   sbit_pkg::word_t exp_pc      = `SBIT_RESET_PC;
   store_t          exp_stores [$];
   int              cycle_cnt   = 0;
   int              fetch_idx;
   int              ibus_wait   = 0;
   int              dbus_wait   = 0;
   logic            ibus_busy   = 1'b0;
   logic            dbus_busy   = 1'b0;
   logic            bus_live    = 1'b0;
   logic            prog_done   = 1'b0;

   sbit_core sbit_core_inst (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Taps 16, 14, 13, 11
   function automatic sbit_pkg::word_t rand_bits(input int n);
      sbit_pkg::word_t v;
      logic            fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic sbit_pkg::reg_addr_t pick_reg();
      sbit_pkg::word_t v;
      v = rand_bits(3);
      return {2'b00, v[2:0]};
   endfunction

   function automatic sbit_pkg::word_t enc_i(input logic [11:0] imm,
      input sbit_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input sbit_pkg::reg_addr_t rd, input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic sbit_pkg::word_t enc_r(input logic [6:0] f7,
      input sbit_pkg::reg_addr_t rs2, input sbit_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input sbit_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic sbit_pkg::word_t enc_s(input logic [11:0] imm,
      input sbit_pkg::reg_addr_t rs2, input sbit_pkg::reg_addr_t rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic sbit_pkg::word_t random_reg_op(input sbit_pkg::reg_addr_t rs2,
      input sbit_pkg::reg_addr_t rs1, input sbit_pkg::reg_addr_t rd);
      sbit_pkg::word_t v;
      v = rand_bits(3);
      case (v[2:0])
         3'd1, 3'd5: return enc_r(7'h20, rs2, rs1, 3'd0, rd);
         3'd2:       return enc_r(7'h00, rs2, rs1, 3'd4, rd);
         3'd3:       return enc_r(7'h00, rs2, rs1, 3'd6, rd);
         3'd4:       return enc_r(7'h00, rs2, rs1, 3'd7, rd);
         default:    return enc_r(7'h00, rs2, rs1, 3'd0, rd);
      endcase
   endfunction

   // Branch, LW, SB and SLTI all retire without effect
   function automatic sbit_pkg::word_t random_noop(input logic [11:0] imm,
      input sbit_pkg::reg_addr_t rs2, input sbit_pkg::reg_addr_t rs1,
      input sbit_pkg::reg_addr_t rd);
      sbit_pkg::word_t v;
      v = rand_bits(2);
      case (v[1:0])
         2'd0:    return enc_i(imm, rs1, 3'd0, rd, 7'h63);
         2'd1:    return enc_i(imm, rs1, 3'd2, rd, 7'h03);
         2'd2:    return enc_s(imm, rs2, rs1, 3'd0);
         default: return enc_i(imm, rs1, 3'd2, rd, 7'h13);
      endcase
   endfunction

   task automatic build_program();
      sbit_pkg::reg_addr_t rd;
      sbit_pkg::reg_addr_t rs1;
      sbit_pkg::reg_addr_t rs2;
      sbit_pkg::reg_addr_t last_rd;
      sbit_pkg::word_t     v;
      logic [11:0]         imm;
      int                  n;
      n       = 0;
      last_rd = 5'd1;
      // Every register in use gets LUI then ADDI before anything reads it
      for (int r = 1; r < 8; r++) begin
         v           = rand_bits(20);
         imem[n]     = {v[19:0], 5'(r), 7'h37};
         v           = rand_bits(12);
         imem[n + 1] = enc_i(v[11:0], 5'(r), 3'd0, 5'(r), 7'h13);
         n += 2;
      end
      while (n < PROG_LEN - 8) begin
         rd  = pick_reg();
         rs1 = pick_reg();
         rs2 = pick_reg();
         v   = rand_bits(12);
         imm = v[11:0];
         v   = rand_bits(3);
         case (v[2:0])
            3'd0, 3'd7: begin
               v       = rand_bits(2);
               imem[n] = enc_i(imm, rs1, IMM_F3[3 * int'(v[1:0]) +: 3], rd, 7'h13);
            end
            3'd1:       imem[n] = random_reg_op(rs2, rs1, rd);
            3'd2:       imem[n] = random_reg_op(rs2, last_rd, rd);
            3'd3: begin
               v       = rand_bits(20);
               imem[n] = {v[19:0], rd, 7'h37};
            end
            3'd4, 3'd5: imem[n] = enc_s(imm, rs2, rs1, 3'd2);
            default:    imem[n] = random_noop(imm, rs2, rs1, rd);
         endcase
         last_rd = rd;
         n++;
      end
      // Dump x0..x7 at the end
      for (int r = 0; r < 8; r++) begin
         rs1     = pick_reg();
         v       = rand_bits(12);
         imem[n] = enc_s(v[11:0], 5'(r), rs1, 3'd2);
         n++;
      end
   endtask

   // RV32I semantics of the kept subset
   task automatic run_model(input sbit_pkg::word_t ins);
      sbit_pkg::word_t a;
      sbit_pkg::word_t b;
      sbit_pkg::word_t imm_i;
      sbit_pkg::word_t res;
      store_t          st;
      logic            wr;
      a     = xreg[ins[19:15]];
      b     = xreg[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      res   = '0;
      wr    = 1'b1;
      case (ins[6:0])
         7'h13: begin
            case (ins[14:12])
               3'd0:    res = a + imm_i;
               3'd4:    res = a ^ imm_i;
               3'd6:    res = a | imm_i;
               3'd7:    res = a & imm_i;
               default: wr = 1'b0;
            endcase
         end
         7'h33: begin
            case ({ins[31:25], ins[14:12]})
               10'h000: res = a + b;
               10'h100: res = a - b;
               10'h004: res = a ^ b;
               10'h006: res = a | b;
               10'h007: res = a & b;
               default: wr = 1'b0;
            endcase
         end
         7'h37: res = {ins[31:12], 12'h000};
         7'h23: begin
            wr = 1'b0;
            if (ins[14:12] == 3'd2) begin
               res    = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
               st.adr = {res[31:2], 2'b00};
               st.dat = b;
               exp_stores.push_back(st);
            end
         end
         default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
         xreg[ins[11:7]] = res;
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_word(input string name, input sbit_pkg::word_t got,
      input sbit_pkg::word_t exp);
      assert (got === exp)
         else abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   // Instruction memory and data sink with random ack latency
   always @(posedge clk) begin
      bus_live = i_rst_n;
      #1;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      if (bus_live && o_ibus_cyc && !prog_done) begin
         if (!ibus_busy) begin
            check_word("o_ibus_adr", o_ibus_adr, exp_pc);
            assert (exp_stores.size() == 0)
               else abort_run("a predicted store never appeared on the data bus");
            ibus_busy = 1'b1;
            ibus_wait = int'(rand_bits(2));
         end
         fetch_idx = int'((exp_pc - `SBIT_RESET_PC) >> 2);
         if (fetch_idx == PROG_LEN) begin
            prog_done = 1'b1;
         end else if (ibus_wait == 0) begin
            i_ibus_rdt = imem[fetch_idx];
            i_ibus_ack = 1'b1;
            ibus_busy  = 1'b0;
            run_model(imem[fetch_idx]);
            exp_pc     = exp_pc + 32'd4;
         end else begin
            ibus_wait--;
         end
      end
      if (bus_live && o_dbus_cyc) begin
         if (!dbus_busy) begin
            assert (exp_stores.size() != 0)
               else abort_run("data bus write without a store in the program");
            dbus_busy = 1'b1;
            dbus_wait = int'(rand_bits(2));
         end
         if (dbus_wait == 0) begin
            check_word("o_dbus_adr", o_dbus_adr, exp_stores[0].adr);
            check_word("o_dbus_dat", o_dbus_dat, exp_stores[0].dat);
            void'(exp_stores.pop_front());
            i_dbus_ack = 1'b1;
            dbus_busy  = 1'b0;
         end else begin
            dbus_wait--;
         end
      end
   end

   initial begin
      i_rst_n = 1'b0;
      lfsr_q  = 16'd22723;
      build_program();
      repeat (5) @(posedge clk);
      #1;
      i_rst_n = 1'b1;
      while (!prog_done && cycle_cnt < TIMEOUT) begin
         @(posedge clk);
      end
      if (prog_done) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         abort_run($sformatf("timeout after %0d cycles before the program ended", cycle_cnt));
      end
   end

endmodule

// File: verif/sbit_assertions.sv
`timescale 1ns/1ps
`include "sbit_settings.svh"

module sbit_assertions (
   input logic            clk,
   input logic            i_rst_n,
   input logic            i_ibus_cyc,
   input sbit_pkg::word_t i_ibus_adr,
   input logic            i_ibus_ack,
   input logic            i_dbus_cyc,
   input sbit_pkg::word_t i_dbus_adr,
   input sbit_pkg::word_t i_dbus_dat,
   input logic            i_dbus_ack
);

   a_first_fetch: assert property (@(posedge clk)
      $rose(i_rst_n) |-> i_ibus_cyc && i_ibus_adr == `SBIT_RESET_PC)
      else $error("first fetch not at the reset PC");

   a_no_overlap: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else $error("instruction and data bus cycles overlap");

   a_ibus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc && $stable(i_ibus_adr))
      else $error("fetch address or cycle dropped before the ack");

   // PC only ever steps by one word
   a_pc_step: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_ibus_cyc) |-> i_ibus_adr == $past(i_ibus_adr) + 32'd4)
      else $error("fetch address did not advance by 4");

   a_dbus_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus_cyc && !i_dbus_ack |=>
         i_dbus_cyc && $stable(i_dbus_adr) && $stable(i_dbus_dat))
      else $error("store address, data or cycle changed before the ack");

endmodule

bind sbit_core sbit_assertions sbit_assertions_inst (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus_cyc (o_ibus_cyc),
   .i_ibus_adr (o_ibus_adr),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus_cyc (o_dbus_cyc),
   .i_dbus_adr (o_dbus_adr),
   .i_dbus_dat (o_dbus_dat),
   .i_dbus_ack (i_dbus_ack)
);

// File: hdl/sbit_core.sv
`timescale 1ns/1ps

module sbit_core (
   input  logic            clk,
   input  logic            i_rst_n,
   output sbit_pkg::word_t o_ibus_adr,
   output logic            o_ibus_cyc,
   input  sbit_pkg::word_t i_ibus_rdt,
   input  logic            i_ibus_ack,
   output sbit_pkg::word_t o_dbus_adr,
   output sbit_pkg::word_t o_dbus_dat,
   output logic            o_dbus_cyc,
   input  logic            i_dbus_ack
);

   sbit_pkg::bit_cnt_t   cnt;
   sbit_pkg::dec_t       dec;
   logic                 cnt_en;
   logic                 fetch_ack;
   logic                 imm_bit;
   logic                 rs1_bit;
   logic                 rs2_bit;
   logic                 rd_bit;

   sbit_sequencer sbit_sequencer_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_dbus_ack  (i_dbus_ack),
      .i_is_store  (dec.is_store),
      .o_state     (),
      .o_cnt       (cnt),
      .o_cnt_en    (cnt_en),
      .o_cnt_done  (),
      .o_fetch_ack (fetch_ack),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_dbus_cyc  (o_dbus_cyc),
      .o_pc        (o_ibus_adr)
   );

   sbit_decode sbit_decode_inst (
      .clk         (clk),
      .i_fetch_ack (fetch_ack),
      .i_cnt_en    (cnt_en),
      .i_instr     (i_ibus_rdt),
      .o_dec       (dec),
      .o_imm_bit   (imm_bit)
   );

   sbit_alu sbit_alu_inst (
      .clk       (clk),
      .i_cnt_en  (cnt_en),
      .i_first   (cnt == '0),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .i_use_imm (dec.use_imm),
      .i_op      (dec.alu_op),
      .o_rd_bit  (rd_bit)
   );

   sbit_rf sbit_rf_inst (
      .clk       (clk),
      .i_wen     (cnt_en & dec.rd_wen),
      .i_cnt     (cnt),
      .i_rs1     (dec.rs1),
      .i_rs2     (dec.rs2),
      .i_rd      (dec.rd),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   // ALU result doubles as the store address
   sbit_store_buf sbit_store_buf_inst (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_addr_bit (rd_bit),
      .i_data_bit (rs2_bit),
      .o_adr      (o_dbus_adr),
      .o_dat      (o_dbus_dat)
   );

endmodule

// File: hdl/sbit_store_buf.sv
`timescale 1ns/1ps

module sbit_store_buf (
   input  logic            clk,
   input  logic            i_cnt_en,
   input  logic            i_addr_bit,
   input  logic            i_data_bit,
   output sbit_pkg::word_t o_adr,
   output sbit_pkg::word_t o_dat
);

   sbit_pkg::word_t adr_q;
   sbit_pkg::word_t dat_q;

   // LSB enters first, so after 32 shifts bit 0 sits at the bottom
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         adr_q <= {i_addr_bit, adr_q[31:1]};
         dat_q <= {i_data_bit, dat_q[31:1]};
      end
   end

   // Word aligned
   assign o_adr = {adr_q[31:2], 2'b00};
   assign o_dat = dat_q;

endmodule

// File: hdl/sbit_rf.sv
`timescale 1ns/1ps

module sbit_rf (
   input  logic                clk,
   input  logic                i_wen,
   input  sbit_pkg::bit_cnt_t  i_cnt,
   input  sbit_pkg::reg_addr_t i_rs1,
   input  sbit_pkg::reg_addr_t i_rs2,
   input  sbit_pkg::reg_addr_t i_rd,
   input  logic                i_rd_bit,
   output logic                o_rs1_bit,
   output logic                o_rs2_bit
);

   // x0 has no storage
   sbit_pkg::word_t regs [1:31];

   logic rs1_zero;
   logic rs2_zero;
   logic rd_zero;

   assign rs1_zero = (i_rs1 == '0);
   assign rs2_zero = (i_rs2 == '0);
   assign rd_zero  = (i_rd == '0);

   always_comb begin
      if (rs1_zero) begin
         o_rs1_bit = 1'b0;
      end else begin
         o_rs1_bit = regs[i_rs1][i_cnt];
      end
   end

   always_comb begin
      if (rs2_zero) begin
         o_rs2_bit = 1'b0;
      end else begin
         o_rs2_bit = regs[i_rs2][i_cnt];
      end
   end

   // Only bit cnt changes, so higher source bits are still intact
   always_ff @(posedge clk) begin
      if (i_wen && !rd_zero) begin
         regs[i_rd][i_cnt] <= i_rd_bit;
      end
   end

endmodule

// File: hdl/sbit_alu.sv
`timescale 1ns/1ps

module sbit_alu (
   input  logic              clk,
   input  logic              i_cnt_en,
   input  logic              i_first,
   input  logic              i_rs1_bit,
   input  logic              i_rs2_bit,
   input  logic              i_imm_bit,
   input  logic              i_use_imm,
   input  sbit_pkg::alu_op_e i_op,
   output logic              o_rd_bit
);

   logic op_b;
   logic add_b;
   logic carry_in;
   logic carry_q;
   logic sum;
   logic carry_out;
   logic is_sub;

   assign is_sub = (i_op == sbit_pkg::SUB);
   assign op_b   = i_use_imm ? i_imm_bit : i_rs2_bit;

   // Two's complement subtract inverts B with a carry in of one
   assign add_b     = op_b ^ is_sub;
   assign carry_in  = i_first ? is_sub : carry_q;
   assign sum       = i_rs1_bit ^ add_b ^ carry_in;
   assign carry_out = (i_rs1_bit & add_b) | (carry_in & (i_rs1_bit ^ add_b));

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_op)
         sbit_pkg::ADD,
         sbit_pkg::SUB:    o_rd_bit = sum;
         sbit_pkg::XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         sbit_pkg::OR:     o_rd_bit = i_rs1_bit | op_b;
         sbit_pkg::AND:    o_rd_bit = i_rs1_bit & op_b;
         sbit_pkg::PASS_B: o_rd_bit = op_b;
         default:          o_rd_bit = 1'b0;
      endcase
   end

endmodule

// File: hdl/sbit_decode.sv
`timescale 1ns/1ps

module sbit_decode (
   input  logic            clk,
   input  logic            i_fetch_ack,
   input  logic            i_cnt_en,
   input  sbit_pkg::word_t i_instr,
   output sbit_pkg::dec_t  o_dec,
   output logic            o_imm_bit
);

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   sbit_pkg::dec_t  dec_d;
   sbit_pkg::dec_t  dec_q;
   sbit_pkg::word_t imm_d;
   sbit_pkg::word_t imm_q;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   always_comb begin
      dec_d        = '0;
      dec_d.rd     = i_instr[11:7];
      dec_d.rs1    = i_instr[19:15];
      dec_d.rs2    = i_instr[24:20];
      dec_d.alu_op = sbit_pkg::ADD;
      imm_d        = {{20{i_instr[31]}}, i_instr[31:20]};
      case (opcode)
         OPC_OP_IMM: begin
            dec_d.use_imm = 1'b1;
            dec_d.rd_wen  = 1'b1;
            case (funct3)
               3'b000:  dec_d.alu_op = sbit_pkg::ADD;
               3'b100:  dec_d.alu_op = sbit_pkg::XOR;
               3'b110:  dec_d.alu_op = sbit_pkg::OR;
               3'b111:  dec_d.alu_op = sbit_pkg::AND;
               // Shifts and compares fall through as no-ops
               default: dec_d.rd_wen = 1'b0;
            endcase
         end
         OPC_OP: begin
            dec_d.rd_wen = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'b000}: dec_d.alu_op = sbit_pkg::ADD;
               {7'h20, 3'b000}: dec_d.alu_op = sbit_pkg::SUB;
               {7'h00, 3'b100}: dec_d.alu_op = sbit_pkg::XOR;
               {7'h00, 3'b110}: dec_d.alu_op = sbit_pkg::OR;
               {7'h00, 3'b111}: dec_d.alu_op = sbit_pkg::AND;
               default:         dec_d.rd_wen = 1'b0;
            endcase
         end
         OPC_LUI: begin
            dec_d.alu_op  = sbit_pkg::PASS_B;
            dec_d.use_imm = 1'b1;
            dec_d.rd_wen  = 1'b1;
            imm_d         = {i_instr[31:12], 12'h000};
         end
         OPC_STORE: begin
            // Word stores only
            dec_d.use_imm  = 1'b1;
            dec_d.is_store = (funct3 == 3'b010);
            imm_d          = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_fetch_ack) begin
         dec_q <= dec_d;
         imm_q <= imm_d;
      end else if (i_cnt_en) begin
         imm_q <= {1'b0, imm_q[31:1]};
      end
   end

   assign o_dec     = dec_q;
   assign o_imm_bit = imm_q[0];

endmodule

// File: hdl/sbit_sequencer.sv
`timescale 1ns/1ps
`include "sbit_settings.svh"

module sbit_sequencer (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_ibus_ack,
   input  logic                 i_dbus_ack,
   input  logic                 i_is_store,
   output sbit_pkg::seq_state_e o_state,
   output sbit_pkg::bit_cnt_t   o_cnt,
   output logic                 o_cnt_en,
   output logic                 o_cnt_done,
   output logic                 o_fetch_ack,
   output logic                 o_ibus_cyc,
   output logic                 o_dbus_cyc,
   output sbit_pkg::word_t      o_pc
);

   sbit_pkg::seq_state_e state_q;
   sbit_pkg::bit_cnt_t   cnt_q;
   sbit_pkg::word_t      pc_q;
   logic                 retire;

   assign o_state     = state_q;
   assign o_cnt       = cnt_q;
   assign o_pc        = pc_q;
   assign o_ibus_cyc  = (state_q == sbit_pkg::FETCH);
   assign o_dbus_cyc  = (state_q == sbit_pkg::STORE);
   assign o_cnt_en    = (state_q == sbit_pkg::EXEC);
   assign o_cnt_done  = o_cnt_en && (cnt_q == sbit_pkg::bit_cnt_t'(`SBIT_XLEN - 1));
   assign o_fetch_ack = o_ibus_cyc & i_ibus_ack;

   // Stores retire on the data ack, everything else at the last bit
   assign retire = (o_cnt_done & ~i_is_store) | (o_dbus_cyc & i_dbus_ack);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= sbit_pkg::FETCH;
         cnt_q   <= '0;
         pc_q    <= `SBIT_RESET_PC;
      end else begin
         if (retire) begin
            pc_q <= pc_q + sbit_pkg::word_t'(4);
         end
         case (state_q)
            sbit_pkg::FETCH: begin
               cnt_q <= '0;
               if (i_ibus_ack) begin
                  state_q <= sbit_pkg::EXEC;
               end
            end
            sbit_pkg::EXEC: begin
               cnt_q <= cnt_q + 1'b1;
               if (o_cnt_done) begin
                  state_q <= i_is_store ? sbit_pkg::STORE : sbit_pkg::FETCH;
               end
            end
            sbit_pkg::STORE: begin
               if (i_dbus_ack) begin
                  state_q <= sbit_pkg::FETCH;
               end
            end
            default: state_q <= sbit_pkg::FETCH;
         endcase
      end
   end

endmodule

// File: hdl/sbit_pkg.sv
`include "sbit_settings.svh"

package sbit_pkg;

   typedef logic [`SBIT_XLEN-1:0]         word_t;
   typedef logic [4:0]                    reg_addr_t;
   typedef logic [$clog2(`SBIT_XLEN)-1:0] bit_cnt_t;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      STORE
   } seq_state_e;

   // PASS_B forwards operand B for LUI
   typedef enum logic [2:0] {
      ADD,
      SUB,
      XOR,
      OR,
      AND,
      PASS_B
   } alu_op_e;

   typedef struct packed {
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      alu_op_e   alu_op;
      logic      use_imm;
      logic      rd_wen;
      logic      is_store;
   } dec_t;

endpackage

// File: hdl/sbit_settings.svh
`ifndef SBIT_SETTINGS_SVH
`define SBIT_SETTINGS_SVH

// First fetch address after reset
`define SBIT_RESET_PC 32'h0000_0000

// The core only works with a 32-bit datapath
`define SBIT_XLEN 32

`endif
